// File: common/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Cause.ExcCode values.
`define EXCCODE_INT   5'h00
`define EXCCODE_TLBL  5'h02
`define EXCCODE_TLBS  5'h03
`define EXCCODE_ADEL  5'h04
`define EXCCODE_ADES  5'h05
`define EXCCODE_SYS   5'h08
`define EXCCODE_BP    5'h09
`define EXCCODE_RI    5'h0a
`define EXCCODE_CPU   5'h0b
`define EXCCODE_OV    5'h0c

// CP0 register numbers for select 0.
`define CP0_COUNT     5'd9
`define CP0_COMPARE   5'd11
`define CP0_STATUS    5'd12
`define CP0_CAUSE     5'd13
`define CP0_EPC       5'd14
`define CP0_ERROR_EPC 5'd30

`define ZERO_WORD 32'h0000_0000

`define VEC_BASE_BOOT   32'hbfc0_0200 // Used while Status.BEV is set.
`define VEC_BASE_NORMAL 32'h8000_0000

`define VEC_OFS_REFILL  16'h0000
`define VEC_OFS_GENERAL 16'h0180
`define VEC_OFS_INT     16'h0200

// Only BEV (bit 22) and ERL (bit 2) are set.
`define STATUS_RESET 32'h0040_0004

`endif

// File: common/cpu_pkg.sv
package cpu_pkg;

	typedef logic        bit_t;
	typedef logic [31:0] word_t;
	typedef logic [15:0] half_word_t;
	typedef logic [31:0] inst_addr_t;
	typedef logic [4:0]  exc_code_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [7:0]  int_vec_t;

	typedef struct packed {
		inst_addr_t pc;
		bit_t       delayslot;
		bit_t       is_priv_inst; // Needs kernel mode or CP0 access.
	} pipeline_data_t;

	typedef struct packed {
		bit_t        occur;
		bit_t        eret;
		exc_code_t   code;
		logic [1:0]  extra; // Coprocessor number for Cause.CE.
	} except_info_t;

	typedef struct packed {
		bit_t     cu0;
		bit_t     bev;
		int_vec_t im;
		bit_t     um;
		bit_t     erl;
		bit_t     exl;
		bit_t     ie;
	} status_t;

	typedef struct packed {
		bit_t       bd;
		bit_t       ti;
		logic [1:0] ce;
		bit_t       iv;
		int_vec_t   ip;
		exc_code_t  exccode;
	} cause_t;

	typedef struct packed {
		status_t    status;
		cause_t     cause;
		inst_addr_t epc;
		inst_addr_t error_epc;
		word_t      count;
		word_t      compare;
	} cp0_regs_t;

	typedef struct packed {
		bit_t       flush;
		bit_t       alpha_taken; // Slot a supplied the faulting PC.
		bit_t       delayslot;
		bit_t       eret;
		exc_code_t  code;
		logic [1:0] extra;
		inst_addr_t cur_pc;
		inst_addr_t jump_pc;
	} except_req_t;

	// Architectural bit positions of Status and Cause.
	function automatic word_t status_to_word(status_t s);
		word_t w;
		w = '0;
		w[28] = s.cu0;
		w[22] = s.bev;
		w[15:8] = s.im;
		w[4] = s.um;
		w[2] = s.erl;
		w[1] = s.exl;
		w[0] = s.ie;
		return w;
	endfunction

	function automatic status_t word_to_status(word_t w);
		return '{cu0: w[28], bev: w[22], im: w[15:8], um: w[4], erl: w[2], exl: w[1], ie: w[0]};
	endfunction

	function automatic word_t cause_to_word(cause_t c);
		word_t w;
		w = '0;
		w[31] = c.bd;
		w[30] = c.ti;
		w[29:28] = c.ce;
		w[23] = c.iv;
		w[15:8] = c.ip;
		w[6:2] = c.exccode;
		return w;
	endfunction

endpackage

// File: except/except_arbiter.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module except_arbiter (
	input  cpu_pkg::bit_t           rst_n,
	input  cpu_pkg::pipeline_data_t data_a,
	input  cpu_pkg::pipeline_data_t data_b,
	input  cpu_pkg::except_info_t   except_a,
	input  cpu_pkg::except_info_t   except_b,
	input  cpu_pkg::cp0_regs_t      cp0_regs,
	output cpu_pkg::except_req_t    except_req
);

	cpu_pkg::int_vec_t     int_active;
	cpu_pkg::bit_t         int_pending;
	cpu_pkg::bit_t         user_mode;
	cpu_pkg::bit_t         cpu_fault;
	cpu_pkg::bit_t         take_a;
	cpu_pkg::except_info_t sel;
	cpu_pkg::half_word_t   offset;
	cpu_pkg::inst_addr_t   vec_base;
	cpu_pkg::inst_addr_t   target;

	assign int_active = cp0_regs.cause.ip & cp0_regs.status.im;

	// Interrupts are taken only with IE set and outside exception or error level.
	assign int_pending = cp0_regs.status.ie && !cp0_regs.status.exl &&
		!cp0_regs.status.erl && (int_active != '0);

	assign user_mode = cp0_regs.status.um && !cp0_regs.status.exl && !cp0_regs.status.erl;
	assign cpu_fault = user_mode && (data_a.is_priv_inst || data_b.is_priv_inst);

	always_comb begin
		sel = '0;
		take_a = 1'b0;
		if (int_pending) begin
			sel.occur = 1'b1;
			sel.code = `EXCCODE_INT;
			take_a = 1'b1; // Interrupts are charged to the older slot.
		end else if (cpu_fault) begin
			sel.occur = 1'b1;
			sel.code = `EXCCODE_CPU;
			sel.extra = 2'd1;
			take_a = data_a.is_priv_inst;
		end else if (except_a.occur) begin
			sel = except_a;
			take_a = 1'b1;
		end else begin
			sel = except_b;
		end
	end

	// Refill and vectored interrupt offsets apply only on first entry.
	always_comb begin
		if (!cp0_regs.status.exl &&
			(sel.code == `EXCCODE_TLBL || sel.code == `EXCCODE_TLBS)) begin
			offset = `VEC_OFS_REFILL;
		end else if (!cp0_regs.status.exl && sel.code == `EXCCODE_INT && cp0_regs.cause.iv) begin
			offset = `VEC_OFS_INT;
		end else begin
			offset = `VEC_OFS_GENERAL;
		end
	end

	assign vec_base = cp0_regs.status.bev ? `VEC_BASE_BOOT : `VEC_BASE_NORMAL;

	always_comb begin
		if (sel.eret) begin
			target = cp0_regs.status.erl ? cp0_regs.error_epc : cp0_regs.epc;
		end else begin
			target = vec_base + {16'h0000, offset};
		end
	end

	always_comb begin
		except_req = '0;
		if (rst_n && sel.occur) begin
			except_req.flush = 1'b1;
			except_req.alpha_taken = take_a;
			except_req.delayslot = take_a ? data_a.delayslot : data_b.delayslot;
			except_req.eret = sel.eret;
			except_req.code = sel.code;
			except_req.extra = sel.extra;
			except_req.cur_pc = take_a ? data_a.pc : data_b.pc;
			except_req.jump_pc = target;
		end
	end

	// Both checks look at the request once it has settled in the time step.
	always_comb begin
		if (rst_n && except_req.flush) begin
			a_flush_has_cause: assert final (int_pending || cpu_fault ||
				except_a.occur || except_b.occur)
				else $error("flush raised without any exception source");
		end
		if (rst_n && except_req.flush && !except_req.eret) begin
			a_legal_vector: assert final (except_req.jump_pc inside {
				`VEC_BASE_BOOT + {16'h0000, `VEC_OFS_REFILL},
				`VEC_BASE_BOOT + {16'h0000, `VEC_OFS_GENERAL},
				`VEC_BASE_BOOT + {16'h0000, `VEC_OFS_INT},
				`VEC_BASE_NORMAL + {16'h0000, `VEC_OFS_REFILL},
				`VEC_BASE_NORMAL + {16'h0000, `VEC_OFS_GENERAL},
				`VEC_BASE_NORMAL + {16'h0000, `VEC_OFS_INT}})
				else $error("jump_pc %h is not an exception vector", except_req.jump_pc);
		end
	end

endmodule

// File: cp0/cp0_regs.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cp0_regs (
	input  cpu_pkg::bit_t        clk,
	input  cpu_pkg::bit_t        rst_n,
	input  logic [5:0]           hw_int,
	input  cpu_pkg::bit_t        cp0_we,
	input  cpu_pkg::reg_addr_t   cp0_waddr,
	input  cpu_pkg::reg_addr_t   cp0_raddr,
	input  cpu_pkg::word_t       cp0_wdata,
	output cpu_pkg::word_t       cp0_rdata,
	input  cpu_pkg::except_req_t except_req,
	output cpu_pkg::cp0_regs_t   cp0_regs
);

	logic [5:0]          int_meta;
	logic [5:0]          int_sync;
	cpu_pkg::status_t    status_reg;
	cpu_pkg::cause_t     cause_reg;
	cpu_pkg::inst_addr_t epc_reg;
	cpu_pkg::inst_addr_t error_epc_reg;
	cpu_pkg::word_t      count_reg;
	cpu_pkg::word_t      compare_reg;
	cpu_pkg::bit_t       count_tick;
	cpu_pkg::bit_t       sw_we;
	cpu_pkg::bit_t       exc_entry;
	cpu_pkg::bit_t       status_sw_wr;
	cpu_pkg::bit_t       compare_sw_wr;
	cpu_pkg::bit_t       ti_next;
	cpu_pkg::inst_addr_t epc_entry;

	assign sw_we = cp0_we && !except_req.flush; // A flush wins over mtc0.
	assign exc_entry = except_req.flush && !except_req.eret;
	assign status_sw_wr = sw_we && cp0_waddr == `CP0_STATUS;
	assign compare_sw_wr = sw_we && cp0_waddr == `CP0_COMPARE;

	// The timer request holds until software writes Compare.
	assign ti_next = compare_sw_wr ? 1'b0 :
		(count_reg == compare_reg) ? 1'b1 : cause_reg.ti;

	// In a branch delay slot EPC points back at the branch.
	assign epc_entry = except_req.delayslot ? except_req.cur_pc - 32'd4 : except_req.cur_pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			int_meta <= '0;
			int_sync <= '0;
		end else begin
			int_meta <= hw_int;
			int_sync <= int_meta;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count_tick <= 1'b0;
			count_reg <= `ZERO_WORD;
		end else if (sw_we && cp0_waddr == `CP0_COUNT) begin
			count_tick <= 1'b0;
			count_reg <= cp0_wdata;
		end else begin
			count_tick <= !count_tick;
			if (count_tick) begin
				count_reg <= count_reg + 32'd1; // Half the core clock rate.
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			compare_reg <= `ZERO_WORD;
		end else if (compare_sw_wr) begin
			compare_reg <= cp0_wdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			status_reg <= cpu_pkg::word_to_status(`STATUS_RESET);
		end else if (except_req.flush) begin
			if (!except_req.eret) begin
				status_reg.exl <= 1'b1;
			end else if (status_reg.erl) begin
				status_reg.erl <= 1'b0; // Error level is left before exception level.
			end else begin
				status_reg.exl <= 1'b0;
			end
		end else if (status_sw_wr) begin
			status_reg <= cpu_pkg::word_to_status(cp0_wdata);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cause_reg <= '0;
		end else begin
			cause_reg.ti <= ti_next;
			// Timer shares line 7 with the last hardware input.
			cause_reg.ip[7:2] <= {int_sync[5] | ti_next, int_sync[4:0]};
			if (exc_entry) begin
				if (!status_reg.exl) begin
					cause_reg.bd <= except_req.delayslot;
				end
				cause_reg.exccode <= except_req.code;
				cause_reg.ce <= except_req.extra;
			end else if (sw_we && cp0_waddr == `CP0_CAUSE) begin
				cause_reg.iv <= cp0_wdata[23];
				cause_reg.ip[1:0] <= cp0_wdata[9:8]; // Software interrupts.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (exc_entry && !status_reg.exl) begin
			epc_reg <= epc_entry;
		end else if (sw_we && cp0_waddr == `CP0_EPC) begin
			epc_reg <= cp0_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (sw_we && cp0_waddr == `CP0_ERROR_EPC) begin
			error_epc_reg <= cp0_wdata;
		end
	end

	always_comb begin
		case (cp0_raddr)
			`CP0_STATUS:    cp0_rdata = cpu_pkg::status_to_word(status_reg);
			`CP0_CAUSE:     cp0_rdata = cpu_pkg::cause_to_word(cause_reg);
			`CP0_EPC:       cp0_rdata = epc_reg;
			`CP0_ERROR_EPC: cp0_rdata = error_epc_reg;
			`CP0_COUNT:     cp0_rdata = count_reg;
			`CP0_COMPARE:   cp0_rdata = compare_reg;
			default:        cp0_rdata = `ZERO_WORD;
		endcase
	end

	assign cp0_regs = '{status: status_reg, cause: cause_reg, epc: epc_reg,
		error_epc: error_epc_reg, count: count_reg, compare: compare_reg};

	// Once eret has dropped EXL it stays low until another exception or a Status write.
	a_eret_exl_stays_clear: assert property (@(posedge clk) disable iff (!rst_n)
		(except_req.flush && except_req.eret && !status_reg.erl) ##1
		(!exc_entry && !status_sw_wr) |=> !status_reg.exl)
		else $error("EXL set again after eret without a new exception");

	a_flush_blocks_mtc0: assert property (@(posedge clk) disable iff (!rst_n)
		(cp0_we && except_req.flush &&
		(cp0_waddr == `CP0_COMPARE || cp0_waddr == `CP0_ERROR_EPC))
		|=> $stable(compare_reg) && $stable(error_epc_reg))
		else $error("mtc0 took effect in a flush cycle");

endmodule

// File: hw/except_unit.sv
`timescale 1ns/100ps

module except_unit (
	input  cpu_pkg::bit_t           clk,
	input  cpu_pkg::bit_t           rst_n,
	input  cpu_pkg::pipeline_data_t data_a,
	input  cpu_pkg::pipeline_data_t data_b,
	input  cpu_pkg::except_info_t   except_a,
	input  cpu_pkg::except_info_t   except_b,
	input  cpu_pkg::bit_t           cp0_we,
	input  cpu_pkg::reg_addr_t      cp0_waddr,
	input  cpu_pkg::word_t          cp0_wdata,
	input  cpu_pkg::reg_addr_t      cp0_raddr,
	output cpu_pkg::word_t          cp0_rdata,
	input  logic [5:0]              hw_int,
	output cpu_pkg::except_req_t    except_req
);

	cpu_pkg::cp0_regs_t cp0_state;

	// The request is combinational toward the pipeline and sampled by CP0 at the edge.
	except_arbiter i_arbiter (
		.rst_n      (rst_n),
		.data_a     (data_a),
		.data_b     (data_b),
		.except_a   (except_a),
		.except_b   (except_b),
		.cp0_regs   (cp0_state),
		.except_req (except_req)
	);

	cp0_regs i_cp0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.hw_int     (hw_int),
		.cp0_we     (cp0_we),
		.cp0_waddr  (cp0_waddr),
		.cp0_raddr  (cp0_raddr),
		.cp0_wdata  (cp0_wdata),
		.cp0_rdata  (cp0_rdata),
		.except_req (except_req),
		.cp0_regs   (cp0_state)
	);

endmodule

// File: tb/tb_except_unit.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module tb_except_unit;

	cpu_pkg::bit_t           clk;
	cpu_pkg::bit_t           rst_n;
	cpu_pkg::pipeline_data_t data_a;
	cpu_pkg::pipeline_data_t data_b;
	cpu_pkg::except_info_t   except_a;
	cpu_pkg::except_info_t   except_b;
	cpu_pkg::bit_t           cp0_we;
	cpu_pkg::reg_addr_t      cp0_waddr;
	cpu_pkg::word_t          cp0_wdata;
	cpu_pkg::reg_addr_t      cp0_raddr;
	cpu_pkg::word_t          cp0_rdata;
	logic [5:0]              hw_int;
	cpu_pkg::except_req_t    except_req;

	int errors = 0;
	int tests_run = 0;
	cpu_pkg::word_t rng_state = 32'hafd1;

	// Reference model of the CP0 state that the arbiter depends on.
	cpu_pkg::status_t    m_status;
	cpu_pkg::bit_t       m_iv;
	cpu_pkg::bit_t       m_bd;
	cpu_pkg::exc_code_t  m_exccode;
	cpu_pkg::inst_addr_t m_epc;
	cpu_pkg::inst_addr_t m_error_epc;

	except_unit i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#200000;
		$display("Simulation time limit reached before the tests completed");
		$display("Verification failed");
		$finish;
	end

	function automatic cpu_pkg::word_t xorshift32();
		cpu_pkg::word_t x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	function automatic cpu_pkg::pipeline_data_t mk_data(input bit ds, input bit priv);
		cpu_pkg::pipeline_data_t d;
		d.pc = xorshift32();
		d.pc[1:0] = 2'b00; // Word aligned.
		d.delayslot = ds;
		d.is_priv_inst = priv;
		return d;
	endfunction

	function automatic cpu_pkg::except_info_t mk_exc(input cpu_pkg::exc_code_t code,
		input bit eret);
		return '{occur: 1'b1, eret: eret, code: code, extra: 2'd0};
	endfunction

	// Expected flush request by the priority and vector rules.
	function automatic cpu_pkg::except_req_t predict_req(input bit int_hit);
		cpu_pkg::except_req_t  r;
		cpu_pkg::except_info_t e;
		cpu_pkg::half_word_t   ofs;
		cpu_pkg::inst_addr_t   base;
		bit                    use_a;
		bit                    user;
		r = '0;
		e = '0;
		use_a = 1'b0;
		user = m_status.um && !m_status.exl && !m_status.erl;
		if (int_hit) begin
			e = mk_exc(`EXCCODE_INT, 1'b0);
			use_a = 1'b1;
		end else if (user && (data_a.is_priv_inst || data_b.is_priv_inst)) begin
			e = mk_exc(`EXCCODE_CPU, 1'b0);
			e.extra = 2'd1;
			use_a = data_a.is_priv_inst;
		end else if (except_a.occur) begin
			e = except_a;
			use_a = 1'b1;
		end else begin
			e = except_b;
		end
		if (!e.occur)
			return r;
		ofs = `VEC_OFS_GENERAL;
		if (!m_status.exl && (e.code == `EXCCODE_TLBL || e.code == `EXCCODE_TLBS))
			ofs = `VEC_OFS_REFILL;
		else if (!m_status.exl && e.code == `EXCCODE_INT && m_iv)
			ofs = `VEC_OFS_INT;
		base = m_status.bev ? `VEC_BASE_BOOT : `VEC_BASE_NORMAL;
		r.flush = 1'b1;
		r.alpha_taken = use_a;
		r.delayslot = use_a ? data_a.delayslot : data_b.delayslot;
		r.eret = e.eret;
		r.code = e.code;
		r.extra = e.extra;
		r.cur_pc = use_a ? data_a.pc : data_b.pc;
		if (e.eret)
			r.jump_pc = m_status.erl ? m_error_epc : m_epc;
		else
			r.jump_pc = base + {16'h0000, ofs};
		return r;
	endfunction

	task automatic apply_flush_model(input cpu_pkg::except_req_t r);
		if (!r.eret) begin
			if (!m_status.exl) begin
				m_epc = r.delayslot ? r.cur_pc - 32'd4 : r.cur_pc;
				m_bd = r.delayslot;
			end
			m_status.exl = 1'b1;
			m_exccode = r.code;
		end else if (m_status.erl) begin
			m_status.erl = 1'b0;
		end else begin
			m_status.exl = 1'b0;
		end
	endtask

	task automatic check_req(input cpu_pkg::except_req_t got, input cpu_pkg::except_req_t exp);
		if (got !== exp) begin
			$display("Error: except_req = %h, expected %h", got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input cpu_pkg::word_t got,
		input cpu_pkg::word_t exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_code(input string name, input cpu_pkg::exc_code_t got,
		input cpu_pkg::exc_code_t exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic write_cp0(input cpu_pkg::reg_addr_t addr, input cpu_pkg::word_t value);
		step();
		cp0_we = 1'b1;
		cp0_waddr = addr;
		cp0_wdata = value;
		step();
		cp0_we = 1'b0;
		case (addr)
			`CP0_STATUS: m_status = '{cu0: value[28], bev: value[22], im: value[15:8],
				um: value[4], erl: value[2], exl: value[1], ie: value[0]};
			`CP0_CAUSE: m_iv = value[23];
			`CP0_EPC: m_epc = value;
			`CP0_ERROR_EPC: m_error_epc = value;
			default: ;
		endcase
	endtask

	task automatic read_cp0(input cpu_pkg::reg_addr_t addr, output cpu_pkg::word_t value);
		step();
		cp0_raddr = addr;
		#3 value = cp0_rdata;
	endtask

	// Drives one cycle of memory-stage contents and checks the request it produces.
	task automatic run_exception(input cpu_pkg::pipeline_data_t pa,
		input cpu_pkg::pipeline_data_t pb, input cpu_pkg::except_info_t ea,
		input cpu_pkg::except_info_t eb);
		cpu_pkg::except_req_t exp;
		step();
		data_a = pa;
		data_b = pb;
		except_a = ea;
		except_b = eb;
		#4 exp = predict_req(1'b0);
		check_req(except_req, exp);
		step();
		except_a = '0;
		except_b = '0;
		data_a.is_priv_inst = 1'b0;
		data_b.is_priv_inst = 1'b0;
		apply_flush_model(exp);
	endtask

	task automatic check_entry_state();
		cpu_pkg::word_t v;
		read_cp0(`CP0_EPC, v);
		check_word("EPC", v, m_epc);
		read_cp0(`CP0_CAUSE, v);
		check_word("Cause.bd", {31'd0, v[31]}, {31'd0, m_bd});
		check_code("Cause.exccode", v[6:2], m_exccode);
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests_run++;
		$display("test %0d %s: %0d errors", tests_run, name, errors - start_errors);
	endtask

	task automatic test_reset_state();
		int start;
		start = errors;
		rst_n = 1'b0;
		cp0_raddr = `CP0_COUNT;
		repeat (2) @(posedge clk);
		#1 check_req(except_req, '0);
		rst_n = 1'b1;
		#2 check_word("Count", cp0_rdata, `ZERO_WORD); // Count has not ticked yet.
		cp0_raddr = `CP0_STATUS;
		#1 check_word("Status", cp0_rdata, `STATUS_RESET);
		check_req(except_req, '0);
		m_status = '{cu0: 1'b0, bev: 1'b1, im: 8'h00, um: 1'b0, erl: 1'b1, exl: 1'b0, ie: 1'b0};
		m_iv = 1'b0;
		finish_test("reset_state", start);
	endtask

	task automatic test_slot_exceptions();
		int start;
		start = errors;
		write_cp0(`CP0_STATUS, 32'h0040_0000); // BEV kept and ERL cleared.
		run_exception(mk_data(1'b1, 1'b0), mk_data(1'b0, 1'b0),
			mk_exc(`EXCCODE_ADEL, 1'b0), mk_exc(`EXCCODE_OV, 1'b0));
		check_entry_state();
		write_cp0(`CP0_STATUS, 32'h0000_0000);
		run_exception(mk_data(1'b0, 1'b0), mk_data(1'b0, 1'b0), '0,
			mk_exc(`EXCCODE_TLBL, 1'b0));
		check_entry_state();
		finish_test("slot_exceptions", start);
	endtask

	task automatic test_nested_exception();
		int start;
		start = errors;
		run_exception(mk_data(1'b1, 1'b0), mk_data(1'b0, 1'b0),
			mk_exc(`EXCCODE_TLBS, 1'b0), '0);
		check_entry_state();
		finish_test("nested_exception", start);
	endtask

	task automatic test_eret();
		int start;
		cpu_pkg::word_t v;
		start = errors;
		write_cp0(`CP0_EPC, xorshift32());
		run_exception(mk_data(1'b0, 1'b0), mk_data(1'b0, 1'b0), mk_exc(5'h00, 1'b1), '0);
		read_cp0(`CP0_STATUS, v);
		check_word("Status.exl", {31'd0, v[1]}, 32'd0);
		write_cp0(`CP0_STATUS, 32'h0000_0004);
		write_cp0(`CP0_ERROR_EPC, xorshift32());
		run_exception(mk_data(1'b0, 1'b0), mk_data(1'b0, 1'b0), mk_exc(5'h00, 1'b1), '0);
		read_cp0(`CP0_STATUS, v);
		check_word("Status.erl", {31'd0, v[2]}, 32'd0);
		finish_test("eret", start);
	endtask

	task automatic test_interrupts();
		int start;
		int wait_cnt;
		bit found;
		cpu_pkg::except_req_t exp;
		start = errors;
		write_cp0(`CP0_CAUSE, 32'h0080_0000);
		write_cp0(`CP0_STATUS, 32'h0000_0401); // IE with hw_int[0] unmasked.
		step();
		data_a = mk_data(1'b0, 1'b0);
		hw_int = 6'b000001;
		found = 1'b0;
		wait_cnt = 0;
		while (!found && wait_cnt < 20) begin
			#4;
			if (except_req.flush) begin
				found = 1'b1;
			end else begin
				step();
				wait_cnt++;
			end
		end
		if (!found) begin
			$display("Timeout: no interrupt flush after hw_int was raised");
			errors++;
		end else begin
			exp = predict_req(1'b1);
			check_req(except_req, exp);
			check_code("except_req.code", except_req.code, `EXCCODE_INT);
			step();
			apply_flush_model(exp);
		end
		hw_int = 6'b000000;
		write_cp0(`CP0_STATUS, 32'h0000_0001); // Everything masked and EXL cleared.
		hw_int = 6'b000001;
		for (int i = 0; i < 10; i++) begin
			step();
			#4;
			if (except_req.flush) begin
				$display("Flush raised for a masked interrupt");
				errors++;
				break;
			end
		end
		hw_int = 6'b000000;
		finish_test("interrupts", start);
	endtask

	task automatic test_timer_privilege();
		int start;
		int wait_cnt;
		cpu_pkg::word_t v;
		start = errors;
		read_cp0(`CP0_COUNT, v);
		write_cp0(`CP0_COMPARE, v + 32'd3);
		read_cp0(`CP0_CAUSE, v);
		check_word("Cause.ti", {31'd0, v[30]}, 32'd0); // The write drops the old request.
		wait_cnt = 0;
		do begin
			read_cp0(`CP0_CAUSE, v);
			wait_cnt++;
		end while (!v[30] && wait_cnt < 30);
		if (!v[30]) begin
			$display("Timeout: Cause.ti never set after Compare was written");
			errors++;
		end
		write_cp0(`CP0_STATUS, 32'h0000_0010); // User mode with interrupts off.
		run_exception(mk_data(1'b0, 1'b0), mk_data(1'b1, 1'b1), '0, '0);
		check_entry_state();
		read_cp0(`CP0_CAUSE, v);
		check_word("Cause.ce", {30'd0, v[29:28]}, 32'd1);
		finish_test("timer_privilege", start);
	endtask

	initial begin
		rst_n = 1'b0;
		data_a = '0;
		data_b = '0;
		except_a = '0;
		except_b = '0;
		cp0_we = 1'b0;
		cp0_waddr = '0;
		cp0_wdata = '0;
		cp0_raddr = '0;
		hw_int = '0;
		test_reset_state();
		test_slot_exceptions();
		test_nested_exception();
		test_eret();
		test_interrupts();
		test_timer_privilege();
		$display("Tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: files.f
+incdir+common
common/cpu_pkg.sv
except/except_arbiter.sv
cp0/cp0_regs.sv
hw/except_unit.sv
tb/tb_except_unit.sv
